/* src/axi_pkg.sv */
/*
 * AXI protocol package
 * Basic field types, burst and response encodings, lane counts
 * and the depth of the on-chip memory
 */
package axi_pkg;

  typedef logic [3:0]  id_t;   // Transaction ID
  typedef logic [15:0] addr_t; // Byte address
  typedef logic [7:0]  len_t;  // Beats minus one
  typedef logic [2:0]  size_t; // log2 of bytes per beat

  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  localparam int unsigned NarrowBytes = 4; // Lanes of the 32-bit link
  localparam int unsigned WideBytes   = 8; // Lanes of the 64-bit ports
  localparam int unsigned MemWords    = 256;

  // Address of the next beat, only INCR bursts move
  function automatic addr_t next_addr(addr_t addr, size_t size, burst_t burst);
    if (burst != burst_incr) begin
      return addr;
    end
    return addr + (addr_t'(1) << size);
  endfunction

endpackage

/* src/axi_bus_pkg.sv */
/*
 * AXI bus package
 * Channel payloads and request/response bundles of the
 * 64-bit ports and of the 32-bit link
 */
package axi_bus_pkg;

  import axi_pkg::*;

  typedef logic [8*WideBytes-1:0]   wide_data_t;
  typedef logic [WideBytes-1:0]     wide_strb_t;
  typedef logic [8*NarrowBytes-1:0] narrow_data_t;
  typedef logic [NarrowBytes-1:0]   narrow_strb_t;

  // Shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ax_chan_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_chan_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } narrow_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    wide_data_t data;
    resp_t      resp;
    logic       last;
  } wide_r_chan_t;

  typedef struct packed {
    id_t          id;
    narrow_data_t data;
    resp_t        resp;
    logic         last;
  } narrow_r_chan_t;

  typedef struct packed {
    ax_chan_t     aw;
    logic         aw_valid;
    wide_w_chan_t w;
    logic         w_valid;
    logic         b_ready;
    ax_chan_t     ar;
    logic         ar_valid;
    logic         r_ready;
  } wide_req_t;

  typedef struct packed {
    ax_chan_t       aw;
    logic           aw_valid;
    narrow_w_chan_t w;
    logic           w_valid;
    logic           b_ready;
    ax_chan_t       ar;
    logic           ar_valid;
    logic           r_ready;
  } narrow_req_t;

  typedef struct packed {
    logic         aw_ready;
    logic         w_ready;
    b_chan_t      b;
    logic         b_valid;
    logic         ar_ready;
    wide_r_chan_t r;
    logic         r_valid;
  } wide_rsp_t;

  typedef struct packed {
    logic           aw_ready;
    logic           w_ready;
    b_chan_t        b;
    logic           b_valid;
    logic           ar_ready;
    narrow_r_chan_t r;
    logic           r_valid;
  } narrow_rsp_t;

endpackage

/* src/axi_dw_downsizer.sv */
/*
 * AXI downsizer, 64-bit slave port to 32-bit master port
 * Full-size beats split into two narrow beats and gathered on reads,
 * narrow beats steered by address bit 2, unsplittable FIXED refused
 */
`timescale 1ns/1ps

module axi_dw_downsizer
  import axi_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  wide_req_t   slv_req_i,
  output wide_rsp_t   slv_rsp_o,
  output narrow_req_t mst_req_o,
  input  narrow_rsp_t mst_rsp_i
);

  typedef enum logic [1:0] {w_idle, w_split, w_err, w_resp} w_state_e;
  typedef enum logic [1:0] {r_idle, r_gather, r_err} r_state_e;

  w_state_e   w_state_q;
  r_state_e   r_state_q;
  ax_chan_t   aw_q;
  ax_chan_t   ar_q;
  logic       aw_valid_q;  // Narrow AW pending
  logic       ar_valid_q;  // Narrow AR pending
  addr_t      w_addr_q;    // Lane of the current narrow W beat
  addr_t      r_addr_q;    // Lane of the current narrow R beat
  len_t       r_cnt_q;     // Error beats left
  wide_data_t r_data_q;
  resp_t      r_resp_q;
  logic       r_last_q;
  logic       r_valid_q;
  logic       w_wide_done; // Narrow beat finishes the wide beat

  // A full-size FIXED burst cannot be split
  function automatic logic refused(ax_chan_t ax);
    return ax.size == 3'd3 && ax.burst == burst_fixed && ax.len != '0;
  endfunction

  function automatic ax_chan_t narrow_ax(ax_chan_t ax);
    ax_chan_t nx;
    nx = ax;
    if (ax.size == 3'd3) begin
      nx.addr  = {ax.addr[15:3], 3'b000};
      nx.len   = len_t'({ax.len, 1'b1}); // Two narrow beats per wide beat
      nx.size  = 3'd2;
      nx.burst = (ax.burst == burst_fixed) ? burst_incr : ax.burst;
    end
    return nx;
  endfunction

  // Full-size bursts walk both halves
  function automatic addr_t lane_step(addr_t addr, ax_chan_t ax);
    if (ax.size == 3'd3) begin
      return next_addr(addr, 3'd2, burst_incr);
    end
    return next_addr(addr, ax.size, ax.burst);
  endfunction

  assign w_wide_done = aw_q.size != 3'd3 || w_addr_q[2];

  always_comb begin
    mst_req_o.aw       = narrow_ax(aw_q);
    mst_req_o.aw_valid = aw_valid_q;
    mst_req_o.w.data   = w_addr_q[2] ? slv_req_i.w.data[32 +: 32] : slv_req_i.w.data[0 +: 32];
    mst_req_o.w.strb   = w_addr_q[2] ? slv_req_i.w.strb[4 +: 4] : slv_req_i.w.strb[0 +: 4];
    mst_req_o.w.last   = slv_req_i.w.last && w_wide_done;
    // W waits until the narrow AW has gone out
    mst_req_o.w_valid  = slv_req_i.w_valid && w_state_q == w_split && !aw_valid_q;
    mst_req_o.b_ready  = slv_req_i.b_ready && w_state_q == w_split;
    mst_req_o.ar       = narrow_ax(ar_q);
    mst_req_o.ar_valid = ar_valid_q;
    mst_req_o.r_ready  = r_state_q == r_gather && !r_valid_q;

    slv_rsp_o.aw_ready = w_state_q == w_idle;
    slv_rsp_o.w_ready  = (w_state_q == w_split && !aw_valid_q && mst_rsp_i.w_ready &&
                          w_wide_done) || w_state_q == w_err;
    slv_rsp_o.b.id     = aw_q.id;
    slv_rsp_o.b.resp   = (w_state_q == w_resp) ? resp_slverr : mst_rsp_i.b.resp;
    slv_rsp_o.b_valid  = (w_state_q == w_split && mst_rsp_i.b_valid) || w_state_q == w_resp;
    slv_rsp_o.ar_ready = r_state_q == r_idle;
    slv_rsp_o.r.id     = ar_q.id;
    slv_rsp_o.r.data   = (r_state_q == r_err) ? '0 : r_data_q;
    slv_rsp_o.r.resp   = (r_state_q == r_err) ? resp_slverr : r_resp_q;
    slv_rsp_o.r.last   = (r_state_q == r_err) ? r_cnt_q == '0 : r_last_q;
    slv_rsp_o.r_valid  = r_valid_q || r_state_q == r_err;
  end

  // Write side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_state_q  <= w_idle;
      aw_valid_q <= 1'b0;
    end else begin
      case (w_state_q)
        w_idle: begin
          if (slv_req_i.aw_valid) begin
            aw_q     <= slv_req_i.aw;
            w_addr_q <= narrow_ax(slv_req_i.aw).addr;
            if (refused(slv_req_i.aw)) begin
              w_state_q <= w_err;
            end else begin
              w_state_q  <= w_split;
              aw_valid_q <= 1'b1;
            end
          end
        end
        w_split: begin
          if (aw_valid_q && mst_rsp_i.aw_ready) aw_valid_q <= 1'b0;
          if (mst_req_o.w_valid && mst_rsp_i.w_ready) begin
            w_addr_q <= lane_step(w_addr_q, aw_q);
          end
          if (mst_rsp_i.b_valid && slv_req_i.b_ready) w_state_q <= w_idle;
        end
        w_err: begin
          if (slv_req_i.w_valid && slv_req_i.w.last) w_state_q <= w_resp; // Drain W first
        end
        w_resp: begin
          if (slv_req_i.b_ready) w_state_q <= w_idle;
        end
        default: w_state_q <= w_idle;
      endcase
    end
  end

  // Read side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_state_q  <= r_idle;
      ar_valid_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      case (r_state_q)
        r_idle: begin
          if (slv_req_i.ar_valid) begin
            ar_q     <= slv_req_i.ar;
            r_addr_q <= narrow_ax(slv_req_i.ar).addr;
            r_cnt_q  <= slv_req_i.ar.len;
            if (refused(slv_req_i.ar)) begin
              r_state_q <= r_err;
            end else begin
              r_state_q  <= r_gather;
              ar_valid_q <= 1'b1;
            end
          end
        end
        r_gather: begin
          if (ar_valid_q && mst_rsp_i.ar_ready) ar_valid_q <= 1'b0;
          if (mst_rsp_i.r_valid && mst_req_o.r_ready) begin
            if (r_addr_q[2]) begin
              r_data_q[32 +: 32] <= mst_rsp_i.r.data;
            end else begin
              r_data_q[0 +: 32] <= mst_rsp_i.r.data;
            end
            // An error on either half sticks
            if (!r_addr_q[2] || ar_q.size != 3'd3 || mst_rsp_i.r.resp != resp_okay) begin
              r_resp_q <= mst_rsp_i.r.resp;
            end
            r_last_q  <= mst_rsp_i.r.last;
            r_valid_q <= ar_q.size != 3'd3 || r_addr_q[2];
            r_addr_q  <= lane_step(r_addr_q, ar_q);
          end
          if (r_valid_q && slv_req_i.r_ready) begin
            r_valid_q <= 1'b0;
            if (r_last_q) r_state_q <= r_idle;
          end
        end
        r_err: begin
          if (slv_req_i.r_ready) begin
            r_cnt_q <= r_cnt_q - 1'b1;
            if (r_cnt_q == '0) r_state_q <= r_idle;
          end
        end
        default: r_state_q <= r_idle;
      endcase
    end
  end

endmodule

/* src/axi_dw_upsizer.sv */
/*
 * AXI upsizer, 32-bit slave port to 64-bit master port
 * Steers narrow beats onto the wide lanes with no added latency
 */
`timescale 1ns/1ps

module axi_dw_upsizer
  import axi_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  narrow_req_t slv_req_i,
  output narrow_rsp_t slv_rsp_o,
  output wide_req_t   mst_req_o,
  input  wide_rsp_t   mst_rsp_i
);

  addr_t  w_addr_q;
  size_t  w_size_q;
  burst_t w_burst_q;
  logic   w_open_q; // Write burst in flight
  addr_t  r_addr_q;
  size_t  r_size_q;
  burst_t r_burst_q;
  logic   r_open_q; // Read burst in flight
  logic   aw_fire;
  logic   w_fire;
  logic   b_fire;
  logic   ar_fire;
  logic   r_fire;

  always_comb begin
    mst_req_o.aw       = slv_req_i.aw;
    mst_req_o.aw_valid = slv_req_i.aw_valid && !w_open_q;
    mst_req_o.w.data   = {2{slv_req_i.w.data}}; // Both lanes, strobes pick one
    mst_req_o.w.strb   = w_addr_q[2] ? {slv_req_i.w.strb, {NarrowBytes{1'b0}}}
                                     : {{NarrowBytes{1'b0}}, slv_req_i.w.strb};
    mst_req_o.w.last   = slv_req_i.w.last;
    mst_req_o.w_valid  = slv_req_i.w_valid && w_open_q;
    mst_req_o.b_ready  = slv_req_i.b_ready;
    mst_req_o.ar       = slv_req_i.ar;
    mst_req_o.ar_valid = slv_req_i.ar_valid && !r_open_q;
    mst_req_o.r_ready  = slv_req_i.r_ready;

    slv_rsp_o.aw_ready = mst_rsp_i.aw_ready && !w_open_q;
    slv_rsp_o.w_ready  = mst_rsp_i.w_ready && w_open_q;
    slv_rsp_o.b        = mst_rsp_i.b;
    slv_rsp_o.b_valid  = mst_rsp_i.b_valid;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready && !r_open_q;
    slv_rsp_o.r.id     = mst_rsp_i.r.id;
    slv_rsp_o.r.data   = r_addr_q[2] ? mst_rsp_i.r.data[32 +: 32] : mst_rsp_i.r.data[0 +: 32];
    slv_rsp_o.r.resp   = mst_rsp_i.r.resp;
    slv_rsp_o.r.last   = mst_rsp_i.r.last;
    slv_rsp_o.r_valid  = mst_rsp_i.r_valid;
  end

  assign aw_fire = mst_req_o.aw_valid && mst_rsp_i.aw_ready;
  assign w_fire  = mst_req_o.w_valid && mst_rsp_i.w_ready;
  assign b_fire  = mst_rsp_i.b_valid && slv_req_i.b_ready;
  assign ar_fire = mst_req_o.ar_valid && mst_rsp_i.ar_ready;
  assign r_fire  = mst_rsp_i.r_valid && slv_req_i.r_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_open_q <= 1'b0;
      r_open_q <= 1'b0;
    end else begin
      if (aw_fire) begin
        w_open_q  <= 1'b1;
        w_addr_q  <= slv_req_i.aw.addr;
        w_size_q  <= slv_req_i.aw.size;
        w_burst_q <= slv_req_i.aw.burst;
      end
      if (w_fire) w_addr_q <= next_addr(w_addr_q, w_size_q, w_burst_q);
      if (b_fire) w_open_q <= 1'b0; // Closes once the response is taken

      if (ar_fire) begin
        r_open_q  <= 1'b1;
        r_addr_q  <= slv_req_i.ar.addr;
        r_size_q  <= slv_req_i.ar.size;
        r_burst_q <= slv_req_i.ar.burst;
      end
      if (r_fire) begin
        r_addr_q <= next_addr(r_addr_q, r_size_q, r_burst_q);
        if (mst_rsp_i.r.last) r_open_q <= 1'b0;
      end
    end
  end

endmodule

/* src/axi_dw_converter.sv */
/*
 * AXI data-width converter
 * Chooses upsizer, downsizer or a straight connection
 * from the widths of its two ports
 */
`timescale 1ns/1ps

module axi_dw_converter #(
  parameter int unsigned SlvDataWidth = 64, // Width of the slave port
  parameter int unsigned MstDataWidth = 64, // Width of the master port
  parameter type         slv_req_t    = logic,
  parameter type         slv_rsp_t    = logic,
  parameter type         mst_req_t    = logic,
  parameter type         mst_rsp_t    = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  slv_req_t slv_req_i,
  output slv_rsp_t slv_rsp_o,
  output mst_req_t mst_req_o,
  input  mst_rsp_t mst_rsp_i
);

  if (MstDataWidth == SlvDataWidth) begin : gen_no_dw_conversion
    assign mst_req_o = slv_req_i;
    assign slv_rsp_o = mst_rsp_i;
  end else if (MstDataWidth > SlvDataWidth) begin : gen_dw_upsize
    axi_dw_upsizer i_axi_dw_upsizer (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .slv_req_i(slv_req_i),
      .slv_rsp_o(slv_rsp_o),
      .mst_req_o(mst_req_o),
      .mst_rsp_i(mst_rsp_i)
    );
  end else begin : gen_dw_downsize
    axi_dw_downsizer i_axi_dw_downsizer (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .slv_req_i(slv_req_i),
      .slv_rsp_o(slv_rsp_o),
      .mst_req_o(mst_req_o),
      .mst_rsp_i(mst_rsp_i)
    );
  end

endmodule

/* src/axi_mem_slave.sv */
/*
 * AXI memory slave, 64-bit data
 * Byte-strobed word array; WRAP bursts answered with SLVERR
 */
`timescale 1ns/1ps

module axi_mem_slave
  import axi_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  wide_req_t slv_req_i,
  output wide_rsp_t slv_rsp_o
);

  typedef enum logic [1:0] {mw_idle, mw_data, mw_resp} mw_state_e;
  typedef enum logic {mr_idle, mr_data} mr_state_e;

  wide_data_t mem_q [MemWords];
  mw_state_e  mw_state_q;
  mr_state_e  mr_state_q;
  ax_chan_t   aw_q; // Address walks per beat
  ax_chan_t   ar_q; // Address walks, len counts down
  logic       w_err;
  logic       r_err;

  assign w_err = aw_q.burst == burst_wrap;
  assign r_err = ar_q.burst == burst_wrap;

  always_comb begin
    slv_rsp_o.aw_ready = mw_state_q == mw_idle;
    slv_rsp_o.w_ready  = mw_state_q == mw_data;
    slv_rsp_o.b.id     = aw_q.id;
    slv_rsp_o.b.resp   = w_err ? resp_slverr : resp_okay;
    slv_rsp_o.b_valid  = mw_state_q == mw_resp;
    slv_rsp_o.ar_ready = mr_state_q == mr_idle;
    slv_rsp_o.r.id     = ar_q.id;
    slv_rsp_o.r.data   = r_err ? '0 : mem_q[ar_q.addr[10:3]];
    slv_rsp_o.r.resp   = r_err ? resp_slverr : resp_okay;
    slv_rsp_o.r.last   = ar_q.len == '0;
    slv_rsp_o.r_valid  = mr_state_q == mr_data;
  end

  always_ff @(posedge clk_i) begin
    if (mw_state_q == mw_data && slv_req_i.w_valid && !w_err) begin
      for (int i = 0; i < WideBytes; i++) begin
        if (slv_req_i.w.strb[i]) begin
          mem_q[aw_q.addr[10:3]][8*i +: 8] <= slv_req_i.w.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mw_state_q <= mw_idle;
    end else begin
      case (mw_state_q)
        mw_idle: begin
          if (slv_req_i.aw_valid) begin
            aw_q       <= slv_req_i.aw;
            mw_state_q <= mw_data;
          end
        end
        mw_data: begin
          if (slv_req_i.w_valid) begin
            aw_q.addr <= next_addr(aw_q.addr, aw_q.size, aw_q.burst);
            if (slv_req_i.w.last) mw_state_q <= mw_resp; // B next cycle
          end
        end
        mw_resp: begin
          if (slv_req_i.b_ready) mw_state_q <= mw_idle;
        end
        default: mw_state_q <= mw_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mr_state_q <= mr_idle;
    end else begin
      case (mr_state_q)
        mr_idle: begin
          if (slv_req_i.ar_valid) begin
            ar_q       <= slv_req_i.ar;
            mr_state_q <= mr_data;
          end
        end
        default: begin
          if (slv_req_i.r_ready) begin
            ar_q.addr <= next_addr(ar_q.addr, ar_q.size, ar_q.burst);
            ar_q.len  <= ar_q.len - 1'b1;
            if (ar_q.len == '0) mr_state_q <= mr_idle;
          end
        end
      endcase
    end
  end

endmodule

/* src/axi_dw_bridge.sv */
/*
 * AXI data-width bridge
 * 64-bit port squeezed through a 32-bit link into a 64-bit memory
 */
`timescale 1ns/1ps

module axi_dw_bridge
  import axi_pkg::*;
  import axi_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  wide_req_t slv_req_i,
  output wide_rsp_t slv_rsp_o
);

  narrow_req_t narrow_req; // 32-bit link
  narrow_rsp_t narrow_rsp;
  wide_req_t   mem_req;
  wide_rsp_t   mem_rsp;

  axi_dw_converter #(
    .SlvDataWidth(8*WideBytes),
    .MstDataWidth(8*NarrowBytes),
    .slv_req_t   (wide_req_t),
    .slv_rsp_t   (wide_rsp_t),
    .mst_req_t   (narrow_req_t),
    .mst_rsp_t   (narrow_rsp_t)
  ) conv_down (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .slv_req_i(slv_req_i),
    .slv_rsp_o(slv_rsp_o),
    .mst_req_o(narrow_req),
    .mst_rsp_i(narrow_rsp)
  );

  axi_dw_converter #(
    .SlvDataWidth(8*NarrowBytes),
    .MstDataWidth(8*WideBytes),
    .slv_req_t   (narrow_req_t),
    .slv_rsp_t   (narrow_rsp_t),
    .mst_req_t   (wide_req_t),
    .mst_rsp_t   (wide_rsp_t)
  ) conv_up (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .slv_req_i(narrow_req),
    .slv_rsp_o(narrow_rsp),
    .mst_req_o(mem_req),
    .mst_rsp_i(mem_rsp)
  );

  axi_mem_slave i_mem (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .slv_req_i(mem_req),
    .slv_rsp_o(mem_rsp)
  );

endmodule

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 40 ns clock, reset held high over the first 5 rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 reset_o = 1'b0; // Released just after the fifth edge
  end

endmodule

/* verif/axi_dw_bridge_checker.sv */
/*
 * Protocol checker for the 64-bit slave port of the bridge
 * Watches the B and R handshakes, reset behavior and R last
 */
`timescale 1ns/1ps

module axi_dw_bridge_checker
  import axi_pkg::*;
  import axi_bus_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input wide_req_t slv_req_i,
  input wide_rsp_t slv_rsp_i
);

  int unsigned fail_cnt = 0; // Polled by the testbench
  len_t        r_left_q;     // R beats still due after the current one

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_left_q <= '0;
    end else if (slv_req_i.ar_valid && slv_rsp_i.ar_ready) begin
      r_left_q <= slv_req_i.ar.len;
    end else if (slv_rsp_i.r_valid && slv_req_i.r_ready) begin
      r_left_q <= r_left_q - 8'd1;
    end
  end

  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_rsp_i.b_valid && !slv_req_i.b_ready |=> slv_rsp_i.b_valid && $stable(slv_rsp_i.b))
    else begin
      $error("B valid dropped or B payload changed before the handshake");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_rsp_i.r_valid && !slv_req_i.r_ready |=> slv_rsp_i.r_valid && $stable(slv_rsp_i.r))
    else begin
      $error("R valid dropped or R payload changed before the handshake");
      fail_cnt++;
    end

  // Synchronous reset, so outputs are low from the second reset edge on
  reset_quiet: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> !slv_rsp_i.b_valid && !slv_rsp_i.r_valid)
    else begin
      $error("Response valid high during reset");
      fail_cnt++;
    end

  r_last_final: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_rsp_i.r_valid && slv_req_i.r_ready |-> slv_rsp_i.r.last == (r_left_q == '0))
    else begin
      $error("R last does not mark the final beat of the burst");
      fail_cnt++;
    end

endmodule

/* verif/axi_dw_bridge_tb.sv */
/*
 * Testbench for the AXI data-width bridge
 * Directed write and read bursts checked against a reference memory
 */
`timescale 1ns/1ps

module axi_dw_bridge_tb
  import axi_pkg::*;
  import axi_bus_pkg::*;
();

  localparam int Skew    = 2;   // Stimulus delay after the rising edge
  localparam int Timeout = 200; // Cycles allowed per wait

  logic         clk_i;
  logic         reset_i;
  wide_req_t    req;
  wide_rsp_t    rsp;
  wide_data_t   ref_mem [MemWords]; // Expected memory contents
  wide_data_t   beat_data [16];     // W beats of the next write
  wide_strb_t   beat_strb [16];
  b_chan_t      got_b;
  wide_r_chan_t got_r;
  logic [31:0]  lfsr_q = 32'h3c56;
  string        chan_names [5] = '{"AW", "W", "AR", "B", "R"};

  tb_clock_gen i_clk_gen (
    .clk_o  (clk_i),
    .reset_o(reset_i)
  );

  axi_dw_bridge UUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .slv_req_i(req),
    .slv_rsp_o(rsp)
  );

  bind axi_dw_bridge axi_dw_bridge_checker i_checker (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .slv_req_i(slv_req_i),
    .slv_rsp_i(slv_rsp_o)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    end
    return v;
  endfunction

  function automatic ax_chan_t make_ax(input id_t id, input addr_t addr, input len_t len,
                                       input size_t size, input burst_t burst);
    return '{id: id, addr: addr, len: len, size: size, burst: burst};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // Channel 0 AW, 1 W, 2 AR, 3 B, 4 R; the caller raises valid first
  task automatic wait_transfer(input int chan, input logic rnd_ready);
    int   cycles;
    logic fired;
    cycles = 0;
    fired  = 1'b0;
    while (!fired) begin
      req.b_ready = (chan == 3) && (!rnd_ready || rand_bits(1) == 64'd1);
      req.r_ready = (chan == 4) && (!rnd_ready || rand_bits(1) == 64'd1);
      @(negedge clk_i);
      case (chan)
        0:       fired = rsp.aw_ready;
        1:       fired = rsp.w_ready;
        2:       fired = rsp.ar_ready;
        3:       fired = rsp.b_valid && req.b_ready;
        default: fired = rsp.r_valid && req.r_ready;
      endcase
      got_b = rsp.b;
      got_r = rsp.r;
      @(posedge clk_i);
      #(Skew);
      cycles++;
      assert (fired || cycles < Timeout)
        else report_failure($sformatf("Timeout waiting for a %s transfer", chan_names[chan]));
    end
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.ar_valid = 1'b0;
    req.b_ready  = 1'b0;
    req.r_ready  = 1'b0;
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk_i);
      assert (!rsp.b_valid && !rsp.r_valid)
        else report_failure("B or R valid raised with no transaction open");
      @(posedge clk_i);
      #(Skew);
    end
  endtask

  task automatic fill_beats(input int n);
    for (int i = 0; i < n; i++) begin
      beat_data[i] = rand_bits(64);
      beat_strb[i] = '1;
    end
  endtask

  task automatic write_burst(input ax_chan_t ax, input logic rnd_ready, input resp_t exp_resp);
    addr_t addr;
    int    lo;
    req.aw       = ax;
    req.aw_valid = 1'b1;
    wait_transfer(0, 1'b0);
    addr = ax.addr;
    for (int i = 0; i <= ax.len; i++) begin
      req.w.data  = beat_data[i];
      req.w.strb  = beat_strb[i];
      req.w.last  = (i == ax.len);
      req.w_valid = 1'b1;
      wait_transfer(1, 1'b0);
      if (exp_resp == resp_okay) begin
        lo = addr[2:0] & ~((1 << ax.size) - 1); // First lane of this beat
        for (int k = lo; k < lo + (1 << ax.size); k++) begin
          if (beat_strb[i][k]) ref_mem[addr[10:3]][8*k +: 8] = beat_data[i][8*k +: 8];
        end
      end
      if (ax.burst == burst_incr) addr = addr + addr_t'(1 << ax.size);
    end
    wait_transfer(3, rnd_ready);
    check_value("b.id", got_b.id, ax.id);
    check_value("b.resp", got_b.resp, exp_resp);
  endtask

  task automatic read_burst(input ax_chan_t ax, input logic rnd_ready, input resp_t exp_resp);
    addr_t addr;
    req.ar       = ax;
    req.ar_valid = 1'b1;
    wait_transfer(2, 1'b0);
    addr = ax.addr;
    for (int i = 0; i <= ax.len; i++) begin
      wait_transfer(4, rnd_ready);
      check_value("r.id", got_r.id, ax.id);
      check_value("r.resp", got_r.resp, exp_resp);
      check_value("r.last", got_r.last, i == ax.len);
      if (exp_resp == resp_okay) check_value("r.data", got_r.data, ref_mem[addr[10:3]]);
      if (ax.burst == burst_incr) addr = addr + addr_t'(1 << ax.size);
    end
    expect_quiet(3); // No extra beat after last
  endtask

  task automatic test_single_beat();
    expect_quiet(8);
    fill_beats(1);
    write_burst(make_ax(4'h3, 16'h0010, 8'd0, 3'd3, burst_incr), 1'b0, resp_okay);
    read_burst(make_ax(4'h5, 16'h0010, 8'd0, 3'd3, burst_incr), 1'b0, resp_okay);
  endtask

  task automatic test_incr_burst(input addr_t addr, input logic rnd_ready);
    fill_beats(4);
    write_burst(make_ax(4'h7, addr, 8'd3, 3'd3, burst_incr), rnd_ready, resp_okay);
    read_burst(make_ax(4'h9, addr, 8'd3, 3'd3, burst_incr), rnd_ready, resp_okay);
  endtask

  // Two 32-bit beats, the first one in the upper half of a word
  task automatic test_narrow_strobes();
    fill_beats(2);
    write_burst(make_ax(4'h1, 16'h0100, 8'd1, 3'd3, burst_incr), 1'b0, resp_okay);
    fill_beats(2);
    beat_strb[0] = 8'b1010_0000; // Bytes 5 and 7
    beat_strb[1] = 8'b0000_0110; // Bytes 1 and 2
    write_burst(make_ax(4'h2, 16'h0104, 8'd1, 3'd2, burst_incr), 1'b0, resp_okay);
    read_burst(make_ax(4'h2, 16'h0100, 8'd1, 3'd3, burst_incr), 1'b0, resp_okay);
  endtask

  task automatic test_fixed_refused();
    ax_chan_t ax;
    ax = make_ax(4'hc, 16'h0040, 8'd1, 3'd3, burst_fixed);
    fill_beats(2);
    write_burst(ax, 1'b0, resp_slverr);
    read_burst(ax, 1'b0, resp_slverr);
    read_burst(make_ax(4'hd, 16'h0040, 8'd0, 3'd3, burst_incr), 1'b0, resp_okay);
  endtask

  task automatic test_wrap();
    ax_chan_t ax;
    ax = make_ax(4'he, 16'h0050, 8'd1, 3'd3, burst_wrap);
    fill_beats(2);
    write_burst(ax, 1'b0, resp_slverr);
    read_burst(ax, 1'b0, resp_slverr);
    read_burst(make_ax(4'hf, 16'h0050, 8'd1, 3'd3, burst_incr), 1'b0, resp_okay);
  endtask

  // Assertion failures of the bound checker
  always @(negedge clk_i) begin
    assert (UUT.i_checker.fail_cnt == 0)
      else report_failure("A protocol assertion on the slave port failed");
  end

  initial begin
    int cycles;
    req    = '0;
    cycles = 0;
    while (reset_i !== 1'b0) begin
      @(posedge clk_i);
      #(Skew);
      cycles++;
      assert (cycles < Timeout) else report_failure("Reset was never released");
    end
    test_single_beat();
    test_incr_burst(16'h0040, 1'b0);
    test_narrow_strobes();
    test_fixed_refused();
    test_wrap();
    test_incr_burst(16'h0080, 1'b1); // Random B and R back-pressure
    if (UUT.i_checker.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      report_failure("A protocol assertion on the slave port failed");
    end
  end

endmodule

/* axi_dw_bridge.f */
src/axi_pkg.sv
src/axi_bus_pkg.sv
src/axi_dw_downsizer.sv
src/axi_dw_upsizer.sv
src/axi_dw_converter.sv
src/axi_mem_slave.sv
src/axi_dw_bridge.sv
verif/tb_clock_gen.sv
verif/axi_dw_bridge_checker.sv
verif/axi_dw_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the AXI data-width bridge testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module axi_dw_bridge_tb -f axi_dw_bridge.f -o axi_dw_bridge_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/axi_dw_bridge_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$log"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
